// File: build.f
src/rv32i_pipe_pkg.sv
src/fet_dec_reg.sv
src/dec_exe_reg.sv
src/mem_access_prep.sv
src/exe_mem_reg.sv
src/mem_wb_reg.sv
src/rv32i_stage_regs.sv
test/tb_stage_regs.sv

// File: run.sh
#!/bin/sh
# compile and run the stage register testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module tb_stage_regs
./obj_dir/Vtb_stage_regs > sim.log
cat sim.log

if grep -q "Some tests failed" sim.log; then
    echo "simulation reported failures"
    exit 1
fi
echo "simulation clean"

// File: src/dec_exe_reg.sv
`timescale 1ns/1ns

module dec_exe_reg #(
    parameter rv32i_pipe_pkg::rv32i_word RESET_PC = 32'h40000000
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          load_i,
    input  logic                          valid_i,
    input  rv32i_pipe_pkg::rv32i_word     pc_i,
    input  rv32i_pipe_pkg::rv32i_word     rs1_data_i,
    input  rv32i_pipe_pkg::rv32i_word     rs2_data_i,
    input  rv32i_pipe_pkg::rv32i_word     u_imm_i,
    input  logic                          mem_read_i,
    input  logic                          mem_write_i,
    input  rv32i_pipe_pkg::load_funct3_e  load_funct3_i,
    input  rv32i_pipe_pkg::store_funct3_e store_funct3_i,
    input  rv32i_pipe_pkg::mar_sel_e      mar_sel_i,
    input  rv32i_pipe_pkg::wb_sel_e       wb_sel_i,
    output logic                          valid_o,
    output rv32i_pipe_pkg::rv32i_word     pc_o,
    output rv32i_pipe_pkg::rv32i_word     rs1_data_o,
    output rv32i_pipe_pkg::rv32i_word     rs2_data_o,
    output rv32i_pipe_pkg::rv32i_word     u_imm_o,
    output logic                          mem_read_o,
    output logic                          mem_write_o,
    output rv32i_pipe_pkg::load_funct3_e  load_funct3_o,
    output rv32i_pipe_pkg::store_funct3_e store_funct3_o,
    output rv32i_pipe_pkg::mar_sel_e      mar_sel_o,
    output rv32i_pipe_pkg::wb_sel_e       wb_sel_o
);

    import rv32i_pipe_pkg::*;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_o        <= 1'b0;
            pc_o           <= RESET_PC;
            rs1_data_o     <= '0;
            rs2_data_o     <= '0;
            u_imm_o        <= '0;
            // control word comes up as a harmless no-op
            mem_read_o     <= 1'b0;
            mem_write_o    <= 1'b0;
            load_funct3_o  <= lb;
            store_funct3_o <= sb;
            mar_sel_o      <= mar_pc;
            wb_sel_o       <= wb_alu;
        end else if (load_i) begin
            valid_o        <= valid_i;
            pc_o           <= pc_i;
            rs1_data_o     <= rs1_data_i;
            rs2_data_o     <= rs2_data_i;
            u_imm_o        <= u_imm_i;
            mem_read_o     <= mem_read_i;
            mem_write_o    <= mem_write_i;
            load_funct3_o  <= load_funct3_i;
            store_funct3_o <= store_funct3_i;
            mar_sel_o      <= mar_sel_i;
            wb_sel_o       <= wb_sel_i;
        end
    end

endmodule : dec_exe_reg

// File: src/exe_mem_reg.sv
`timescale 1ns/1ns

module exe_mem_reg #(
    parameter rv32i_pipe_pkg::rv32i_word RESET_PC = 32'h40000000
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          load_i,
    input  logic                          valid_i,
    input  rv32i_pipe_pkg::rv32i_word     pc_i,
    input  rv32i_pipe_pkg::rv32i_word     alu_out_i,
    input  rv32i_pipe_pkg::rv32i_word     rs2_data_i,
    input  rv32i_pipe_pkg::rv32i_word     u_imm_i,
    input  logic                          br_en_i,
    input  logic                          mem_read_i,
    input  logic                          mem_write_i,
    input  rv32i_pipe_pkg::load_funct3_e  load_funct3_i,
    input  rv32i_pipe_pkg::store_funct3_e store_funct3_i,
    input  rv32i_pipe_pkg::mar_sel_e      mar_sel_i,
    input  rv32i_pipe_pkg::wb_sel_e       wb_sel_i,
    output logic                          valid_o,
    output rv32i_pipe_pkg::rv32i_word     pc_o,
    output rv32i_pipe_pkg::rv32i_word     alu_out_o,
    output rv32i_pipe_pkg::rv32i_word     u_imm_o,
    output logic                          br_en_o,
    output rv32i_pipe_pkg::wb_sel_e       wb_sel_o,
    output logic                          mem_read_o,
    output logic                          mem_write_o,
    output rv32i_pipe_pkg::rv32i_word     mem_address_o,
    output rv32i_pipe_pkg::rv32i_word     mem_wdata_o,
    output rv32i_pipe_pkg::byte_en_t      mem_byte_enable_o
);

    import rv32i_pipe_pkg::*;

    logic      mem_read_q;
    logic      mem_write_q;
    logic      capture;
    logic      req_capture;
    rv32i_word prep_addr;
    byte_en_t  prep_byte_en;

    // data only moves for a live instruction
    assign capture     = load_i & valid_i;
    assign req_capture = capture & (mem_read_i | mem_write_i);

    mem_access_prep mem_access_prep_inst (
        .mem_read_i     (mem_read_i),
        .mem_write_i    (mem_write_i),
        .load_funct3_i  (load_funct3_i),
        .store_funct3_i (store_funct3_i),
        .mar_sel_i      (mar_sel_i),
        .pc_i           (pc_i),
        .alu_out_i      (alu_out_i),
        .addr_o         (prep_addr),
        .byte_en_o      (prep_byte_en)
    );

    // valid follows upstream on every load
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_o <= 1'b0;
        end else if (load_i) begin
            valid_o <= valid_i;
        end
    end

    // execute results and later-stage control
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc_o        <= RESET_PC;
            alu_out_o   <= '0;
            u_imm_o     <= '0;
            br_en_o     <= 1'b0;
            wb_sel_o    <= wb_alu;
            mem_read_q  <= 1'b0;
            mem_write_q <= 1'b0;
        end else if (capture) begin
            pc_o        <= pc_i;
            alu_out_o   <= alu_out_i;
            u_imm_o     <= u_imm_i;
            br_en_o     <= br_en_i;
            wb_sel_o    <= wb_sel_i;
            mem_read_q  <= mem_read_i;
            mem_write_q <= mem_write_i;
        end
    end

    // cache request primed on the same edge so memory starts at once
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mem_address_o     <= '0;
            mem_wdata_o       <= '0;
            mem_byte_enable_o <= 4'b0000;
        end else if (req_capture) begin
            mem_address_o     <= prep_addr;
            mem_wdata_o       <= rs2_data_i;
            mem_byte_enable_o <= prep_byte_en;
        end
    end

    // a bubble in memory never strobes the cache
    assign mem_read_o  = mem_read_q & valid_o;
    assign mem_write_o = mem_write_q & valid_o;

endmodule : exe_mem_reg

// File: src/fet_dec_reg.sv
`timescale 1ns/1ns

module fet_dec_reg #(
    parameter rv32i_pipe_pkg::rv32i_word RESET_PC = 32'h40000000
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      load_i,
    input  logic                      valid_i,
    input  rv32i_pipe_pkg::rv32i_word instr_i,
    input  rv32i_pipe_pkg::rv32i_word pc_i,
    output logic                      valid_o,
    output rv32i_pipe_pkg::rv32i_word instr_o,
    output rv32i_pipe_pkg::rv32i_word pc_o
);

    // fetched instruction waits here for the decoder
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_o <= 1'b0;
            instr_o <= '0;
            pc_o    <= RESET_PC;
        end else if (load_i) begin
            // bubble from fetch clears valid here too
            valid_o <= valid_i;
            instr_o <= instr_i;
            pc_o    <= pc_i;
        end
    end

endmodule : fet_dec_reg

// File: src/mem_access_prep.sv
`timescale 1ns/1ns

module mem_access_prep (
    input  logic                          mem_read_i,
    input  logic                          mem_write_i,
    input  rv32i_pipe_pkg::load_funct3_e  load_funct3_i,
    input  rv32i_pipe_pkg::store_funct3_e store_funct3_i,
    input  rv32i_pipe_pkg::mar_sel_e      mar_sel_i,
    input  rv32i_pipe_pkg::rv32i_word     pc_i,
    input  rv32i_pipe_pkg::rv32i_word     alu_out_i,
    output rv32i_pipe_pkg::rv32i_word     addr_o,
    output rv32i_pipe_pkg::byte_en_t      byte_en_o
);

    import rv32i_pipe_pkg::*;

    rv32i_word sel_addr;
    rv32i_word word_addr;
    logic [1:0] offset;

    // address mux
    assign sel_addr  = (mar_sel_i == mar_alu) ? alu_out_i : pc_i;
    assign offset    = sel_addr[1:0];
    assign word_addr = {sel_addr[xlen-1:2], 2'b00};

    // reads win over writes if both are set
    always_comb begin
        byte_en_o = 4'b0000;
        addr_o    = sel_addr;
        if (mem_read_i) begin
            unique case (load_funct3_i)
                lw: byte_en_o = 4'b1111;
                lh, lhu: begin
                    byte_en_o = 4'b0011 << offset;
                    addr_o    = word_addr;
                end
                lb, lbu: begin
                    byte_en_o = 4'b0001 << offset;
                    addr_o    = word_addr;
                end
                default: byte_en_o = 4'b0000;
            endcase
        end else if (mem_write_i) begin
            unique case (store_funct3_i)
                sw: byte_en_o = 4'b1111;
                sh: begin
                    // offset 3 drops the upper lane
                    byte_en_o = 4'b0011 << offset;
                    addr_o    = word_addr;
                end
                sb: begin
                    byte_en_o = 4'b0001 << offset;
                    addr_o    = word_addr;
                end
                default: byte_en_o = 4'b0000;
            endcase
        end
    end

endmodule : mem_access_prep

// File: src/mem_wb_reg.sv
`timescale 1ns/1ns

module mem_wb_reg #(
    parameter rv32i_pipe_pkg::rv32i_word RESET_PC = 32'h40000000
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      load_i,
    input  logic                      valid_i,
    input  rv32i_pipe_pkg::rv32i_word pc_i,
    input  rv32i_pipe_pkg::rv32i_word alu_out_i,
    input  rv32i_pipe_pkg::rv32i_word u_imm_i,
    input  logic                      br_en_i,
    input  rv32i_pipe_pkg::wb_sel_e   wb_sel_i,
    input  rv32i_pipe_pkg::rv32i_word mem_rdata_i,
    output logic                      valid_o,
    output rv32i_pipe_pkg::rv32i_word pc_o,
    output rv32i_pipe_pkg::rv32i_word alu_out_o,
    output rv32i_pipe_pkg::rv32i_word u_imm_o,
    output logic                      br_en_o,
    output rv32i_pipe_pkg::wb_sel_e   wb_sel_o,
    output rv32i_pipe_pkg::rv32i_word mem_rdata_o
);

    import rv32i_pipe_pkg::*;

    logic capture;

    assign capture = load_i & valid_i;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_o <= 1'b0;
        end else if (load_i) begin
            valid_o <= valid_i;
        end
    end

    // everything the writeback mux can pick from
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc_o        <= RESET_PC;
            alu_out_o   <= '0;
            u_imm_o     <= '0;
            br_en_o     <= 1'b0;
            wb_sel_o    <= wb_alu;
            mem_rdata_o <= '0;
        end else if (capture) begin
            pc_o        <= pc_i;
            alu_out_o   <= alu_out_i;
            u_imm_o     <= u_imm_i;
            br_en_o     <= br_en_i;
            wb_sel_o    <= wb_sel_i;
            // cache data returns during the memory cycle
            mem_rdata_o <= mem_rdata_i;
        end
    end

endmodule : mem_wb_reg

// File: src/rv32i_pipe_pkg.sv
package rv32i_pipe_pkg;

    // data path width of the core
    parameter int xlen = 32;

    typedef logic [xlen-1:0] rv32i_word;

    // cache byte enable, one bit per byte lane
    typedef logic [3:0] byte_en_t;

    // RV32I load funct3 codes
    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        lbu = 3'b100,
        lhu = 3'b101
    } load_funct3_e;

    // RV32I store funct3 codes
    typedef enum logic [2:0] {
        sb = 3'b000,
        sh = 3'b001,
        sw = 3'b010
    } store_funct3_e;

    // source of the data cache address
    typedef enum logic {
        mar_pc  = 1'b0,
        mar_alu = 1'b1
    } mar_sel_e;

    // register file writeback source
    typedef enum logic [2:0] {
        wb_alu   = 3'b000,
        wb_mem   = 3'b001,
        wb_pc4   = 3'b010,
        wb_u_imm = 3'b011,
        wb_br_en = 3'b100
    } wb_sel_e;

endpackage : rv32i_pipe_pkg

// File: src/rv32i_stage_regs.sv
`timescale 1ns/1ns

module rv32i_stage_regs #(
    parameter rv32i_pipe_pkg::rv32i_word RESET_PC = 32'h40000000
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          fet_dec_load_i,
    input  logic                          dec_exe_load_i,
    input  logic                          exe_mem_load_i,
    input  logic                          mem_wb_load_i,
    input  logic                          fetch_valid_i,
    input  rv32i_pipe_pkg::rv32i_word     instr_i,
    input  rv32i_pipe_pkg::rv32i_word     fetch_pc_i,
    input  rv32i_pipe_pkg::rv32i_word     dec_pc_i,
    input  logic                          dec_valid_i,
    input  rv32i_pipe_pkg::rv32i_word     rs1_data_i,
    input  rv32i_pipe_pkg::rv32i_word     rs2_data_i,
    input  rv32i_pipe_pkg::rv32i_word     u_imm_i,
    input  logic                          mem_read_i,
    input  logic                          mem_write_i,
    input  rv32i_pipe_pkg::load_funct3_e  load_funct3_i,
    input  rv32i_pipe_pkg::store_funct3_e store_funct3_i,
    input  rv32i_pipe_pkg::mar_sel_e      mar_sel_i,
    input  rv32i_pipe_pkg::wb_sel_e       wb_sel_i,
    input  rv32i_pipe_pkg::rv32i_word     alu_out_i,
    input  logic                          br_en_i,
    input  rv32i_pipe_pkg::rv32i_word     mem_rdata_i,
    output logic                          dec_valid_o,
    output rv32i_pipe_pkg::rv32i_word     dec_instr_o,
    output rv32i_pipe_pkg::rv32i_word     dec_pc_o,
    output logic                          exe_valid_o,
    output rv32i_pipe_pkg::rv32i_word     exe_pc_o,
    output rv32i_pipe_pkg::rv32i_word     exe_rs1_data_o,
    output rv32i_pipe_pkg::rv32i_word     exe_rs2_data_o,
    output rv32i_pipe_pkg::rv32i_word     exe_u_imm_o,
    output logic                          mem_read_o,
    output logic                          mem_write_o,
    output rv32i_pipe_pkg::rv32i_word     mem_address_o,
    output rv32i_pipe_pkg::rv32i_word     mem_wdata_o,
    output rv32i_pipe_pkg::byte_en_t      mem_byte_enable_o,
    output logic                          wb_valid_o,
    output rv32i_pipe_pkg::rv32i_word     wb_pc_o,
    output rv32i_pipe_pkg::rv32i_word     wb_alu_out_o,
    output rv32i_pipe_pkg::rv32i_word     wb_u_imm_o,
    output logic                          wb_br_en_o,
    output rv32i_pipe_pkg::wb_sel_e       wb_sel_o,
    output rv32i_pipe_pkg::rv32i_word     wb_mem_rdata_o
);

    import rv32i_pipe_pkg::*;

    // execute-stage control word
    logic          exe_mem_read;
    logic          exe_mem_write;
    load_funct3_e  exe_load_funct3;
    store_funct3_e exe_store_funct3;
    mar_sel_e      exe_mar_sel;
    wb_sel_e       exe_wb_sel;

    // memory-stage values headed for writeback
    logic          mem_valid;
    rv32i_word     mem_pc;
    rv32i_word     mem_alu_out;
    rv32i_word     mem_u_imm;
    logic          mem_br_en;
    wb_sel_e       mem_wb_sel;

    fet_dec_reg #(.RESET_PC(RESET_PC)) fet_dec_reg_inst (
        .clk(clk), .rst(rst), .load_i(fet_dec_load_i),
        .valid_i(fetch_valid_i), .instr_i(instr_i), .pc_i(fetch_pc_i),
        .valid_o(dec_valid_o), .instr_o(dec_instr_o), .pc_o(dec_pc_o)
    );

    // decoder returns its valid alongside the decoded fields
    dec_exe_reg #(.RESET_PC(RESET_PC)) dec_exe_reg_inst (
        .clk(clk), .rst(rst), .load_i(dec_exe_load_i), .valid_i(dec_valid_i),
        .pc_i(dec_pc_i), .rs1_data_i(rs1_data_i), .rs2_data_i(rs2_data_i),
        .u_imm_i(u_imm_i), .mem_read_i(mem_read_i), .mem_write_i(mem_write_i),
        .load_funct3_i(load_funct3_i), .store_funct3_i(store_funct3_i),
        .mar_sel_i(mar_sel_i), .wb_sel_i(wb_sel_i),
        .valid_o(exe_valid_o), .pc_o(exe_pc_o), .rs1_data_o(exe_rs1_data_o),
        .rs2_data_o(exe_rs2_data_o), .u_imm_o(exe_u_imm_o),
        .mem_read_o(exe_mem_read), .mem_write_o(exe_mem_write),
        .load_funct3_o(exe_load_funct3), .store_funct3_o(exe_store_funct3),
        .mar_sel_o(exe_mar_sel), .wb_sel_o(exe_wb_sel)
    );

    exe_mem_reg #(.RESET_PC(RESET_PC)) exe_mem_reg_inst (
        .clk(clk), .rst(rst), .load_i(exe_mem_load_i), .valid_i(exe_valid_o),
        .pc_i(exe_pc_o), .alu_out_i(alu_out_i), .rs2_data_i(exe_rs2_data_o),
        .u_imm_i(exe_u_imm_o), .br_en_i(br_en_i),
        .mem_read_i(exe_mem_read), .mem_write_i(exe_mem_write),
        .load_funct3_i(exe_load_funct3), .store_funct3_i(exe_store_funct3),
        .mar_sel_i(exe_mar_sel), .wb_sel_i(exe_wb_sel),
        .valid_o(mem_valid), .pc_o(mem_pc), .alu_out_o(mem_alu_out),
        .u_imm_o(mem_u_imm), .br_en_o(mem_br_en), .wb_sel_o(mem_wb_sel),
        .mem_read_o(mem_read_o), .mem_write_o(mem_write_o),
        .mem_address_o(mem_address_o), .mem_wdata_o(mem_wdata_o),
        .mem_byte_enable_o(mem_byte_enable_o)
    );

    mem_wb_reg #(.RESET_PC(RESET_PC)) mem_wb_reg_inst (
        .clk(clk), .rst(rst), .load_i(mem_wb_load_i), .valid_i(mem_valid),
        .pc_i(mem_pc), .alu_out_i(mem_alu_out), .u_imm_i(mem_u_imm),
        .br_en_i(mem_br_en), .wb_sel_i(mem_wb_sel), .mem_rdata_i(mem_rdata_i),
        .valid_o(wb_valid_o), .pc_o(wb_pc_o), .alu_out_o(wb_alu_out_o),
        .u_imm_o(wb_u_imm_o), .br_en_o(wb_br_en_o), .wb_sel_o(wb_sel_o),
        .mem_rdata_o(wb_mem_rdata_o)
    );

endmodule : rv32i_stage_regs

// File: test/tb_stage_regs.sv
`timescale 1ns/1ns

module tb_stage_regs;

    import rv32i_pipe_pkg::*;

    localparam int        clk_period   = 4;
    localparam int        reset_cycles = 16;
    localparam int        test_cycles  = 400;
    localparam int        stall_start  = 150;
    localparam rv32i_word reset_pc     = 32'h40000000;

    // values carried from execute to writeback
    typedef struct packed {
        rv32i_word pc, alu, u_imm;
        logic      br;
        wb_sel_e   wb_sel;
    } carry_t;

    logic          clk = 1'b0;
    logic          rst = 1'b1;
    logic          fet_dec_load_i, dec_exe_load_i, exe_mem_load_i, mem_wb_load_i;
    logic          fetch_valid_i, dec_valid_i, mem_read_i, mem_write_i, br_en_i;
    rv32i_word     instr_i, fetch_pc_i, dec_pc_i, rs1_data_i, rs2_data_i;
    rv32i_word     u_imm_i, alu_out_i, mem_rdata_i;
    load_funct3_e  load_funct3_i;
    store_funct3_e store_funct3_i;
    mar_sel_e      mar_sel_i;
    wb_sel_e       wb_sel_i;
    logic          dec_valid_o, exe_valid_o, wb_valid_o, wb_br_en_o;
    logic          mem_read_o, mem_write_o;
    rv32i_word     dec_instr_o, dec_pc_o, exe_pc_o, exe_rs1_data_o, exe_rs2_data_o;
    rv32i_word     exe_u_imm_o, mem_address_o, mem_wdata_o, wb_pc_o, wb_alu_out_o;
    rv32i_word     wb_u_imm_o, wb_mem_rdata_o;
    byte_en_t      mem_byte_enable_o;
    wb_sel_e       wb_sel_o;

    // one model record per stage register
    struct packed {
        logic      valid;
        rv32i_word instr, pc;
    } m_dec;
    struct packed {
        logic          valid, rd, wr;
        rv32i_word     pc, rs1, rs2, u_imm;
        load_funct3_e  lf3;
        store_funct3_e sf3;
        mar_sel_e      mar;
        wb_sel_e       wb_sel;
    } m_exe;
    struct packed {
        logic      valid, rd, wr;
        carry_t    carry;
        rv32i_word addr, wdata;
        byte_en_t  be;
    } m_mem;
    struct packed {
        logic      valid;
        carry_t    carry;
        rv32i_word rdata;
    } m_wb;

    int            errors = 0;
    int            checks = 0;
    load_funct3_e  load_tab[5] = '{lb, lh, lw, lbu, lhu};
    store_funct3_e store_tab[3] = '{sb, sh, sw};
    wb_sel_e       wb_tab[5] = '{wb_alu, wb_mem, wb_pc4, wb_u_imm, wb_br_en};

    rv32i_stage_regs rv32i_stage_regs_inst (.*);

    always #(clk_period / 2) clk = ~clk;

    // bytes touched by the access now in execute
    function automatic int access_bytes();
        if (m_exe.rd)
            return (m_exe.lf3 == lw) ? 4 : ((m_exe.lf3 inside {lh, lhu}) ? 2 : 1);
        if (m_exe.wr)
            return (m_exe.sf3 == sw) ? 4 : ((m_exe.sf3 == sh) ? 2 : 1);
        return 0;
    endfunction

    task automatic check_val(input string name, input rv32i_word exp, input rv32i_word act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    // later stages first so each one sees the old upstream state
    always @(posedge clk or posedge rst) begin
        rv32i_word sel;
        int        nbytes;
        byte_en_t  lanes;
        if (rst) begin
            m_dec = '0;
            m_exe = '0;
            m_mem = '0;
            m_wb  = '0;
            m_dec.pc       = reset_pc;
            m_exe.pc       = reset_pc;
            m_mem.carry.pc = reset_pc;
            m_wb.carry.pc  = reset_pc;
        end else begin
            if (mem_wb_load_i) begin
                m_wb.valid = m_mem.valid;
                if (m_mem.valid) begin
                    m_wb.carry = m_mem.carry;
                    m_wb.rdata = mem_rdata_i;
                end
            end
            if (exe_mem_load_i) begin
                m_mem.valid = m_exe.valid;
                if (m_exe.valid) begin
                    m_mem.carry = '{m_exe.pc, alu_out_i, m_exe.u_imm, br_en_i, m_exe.wb_sel};
                    m_mem.rd    = m_exe.rd;
                    m_mem.wr    = m_exe.wr;
                    nbytes = access_bytes();
                    if (nbytes != 0) begin
                        sel   = (m_exe.mar == mar_alu) ? alu_out_i : m_exe.pc;
                        lanes = (nbytes == 1) ? 4'b0001 : 4'b0011;
                        // sub-word accesses point at the containing word
                        m_mem.addr  = (nbytes == 4) ? sel : (sel & ~32'h3);
                        m_mem.be    = (nbytes == 4) ? 4'b1111 : lanes << sel[1:0];
                        m_mem.wdata = m_exe.rs2;
                    end
                end
            end
            if (dec_exe_load_i) begin
                m_exe = '{dec_valid_i, mem_read_i, mem_write_i, dec_pc_i, rs1_data_i,
                          rs2_data_i, u_imm_i, load_funct3_i, store_funct3_i, mar_sel_i,
                          wb_sel_i};
            end
            if (fet_dec_load_i) begin
                m_dec = '{fetch_valid_i, instr_i, fetch_pc_i};
            end
        end
    end

    // valids and strobes low and PCs at the reset vector
    assert property (@(negedge clk) rst |-> (!dec_valid_o && !exe_valid_o && !wb_valid_o
                     && !mem_read_o && !mem_write_o && mem_byte_enable_o == 4'b0000
                     && dec_pc_o == reset_pc && exe_pc_o == reset_pc && wb_pc_o == reset_pc))
        else begin
            errors++;
            $display("reset state wrong at %0t, a valid or strobe is set or a PC moved", $time);
        end

    // every output against the model at mid-cycle
    always @(negedge clk) begin
        if (!rst) begin
            check_val("dec_valid_o", 32'(m_dec.valid), 32'(dec_valid_o));
            check_val("dec_instr_o", m_dec.instr, dec_instr_o);
            check_val("dec_pc_o", m_dec.pc, dec_pc_o);
            check_val("exe_valid_o", 32'(m_exe.valid), 32'(exe_valid_o));
            check_val("exe_pc_o", m_exe.pc, exe_pc_o);
            check_val("exe_rs1_data_o", m_exe.rs1, exe_rs1_data_o);
            check_val("exe_rs2_data_o", m_exe.rs2, exe_rs2_data_o);
            check_val("exe_u_imm_o", m_exe.u_imm, exe_u_imm_o);
            check_val("mem_read_o", 32'(m_mem.rd & m_mem.valid), 32'(mem_read_o));
            check_val("mem_write_o", 32'(m_mem.wr & m_mem.valid), 32'(mem_write_o));
            check_val("mem_address_o", m_mem.addr, mem_address_o);
            check_val("mem_wdata_o", m_mem.wdata, mem_wdata_o);
            check_val("mem_byte_enable_o", 32'(m_mem.be), 32'(mem_byte_enable_o));
            check_val("wb_valid_o", 32'(m_wb.valid), 32'(wb_valid_o));
            check_val("wb_pc_o", m_wb.carry.pc, wb_pc_o);
            check_val("wb_alu_out_o", m_wb.carry.alu, wb_alu_out_o);
            check_val("wb_u_imm_o", m_wb.carry.u_imm, wb_u_imm_o);
            check_val("wb_br_en_o", 32'(m_wb.carry.br), 32'(wb_br_en_o));
            check_val("wb_sel_o", 32'(m_wb.carry.wb_sel), 32'(wb_sel_o));
            check_val("wb_mem_rdata_o", m_wb.rdata, wb_mem_rdata_o);
        end
    end

    // loads stay high until stalls are allowed
    task automatic drive_inputs(input logic stalls);
        int pick;
        fet_dec_load_i = !stalls || ($urandom % 4 != 0);
        dec_exe_load_i = !stalls || ($urandom % 4 != 0);
        exe_mem_load_i = !stalls || ($urandom % 4 != 0);
        mem_wb_load_i  = !stalls || ($urandom % 4 != 0);
        fetch_valid_i  = ($urandom % 4 != 0);
        dec_valid_i    = ($urandom % 4 != 0);
        instr_i        = $urandom;
        fetch_pc_i     = $urandom;
        dec_pc_i       = $urandom;
        rs1_data_i     = $urandom;
        // equal operands now and then so br_en goes high
        rs2_data_i     = ($urandom % 8 == 0) ? rs1_data_i : $urandom;
        u_imm_i        = $urandom & 32'hfffff000;
        mem_rdata_i    = $urandom;
        pick           = $urandom % 3;
        mem_read_i     = (pick == 1);
        mem_write_i    = (pick == 2);
        pick           = $urandom % 5;
        load_funct3_i  = load_tab[pick];
        pick           = $urandom % 3;
        store_funct3_i = store_tab[pick];
        mar_sel_i      = ($urandom % 2 == 0) ? mar_pc : mar_alu;
        pick           = $urandom % 5;
        wb_sel_i       = wb_tab[pick];
    endtask

    initial begin
        int cycle;
        void'($urandom(79117));
        drive_inputs(1'b0);
        alu_out_i = '0;
        br_en_i   = 1'b0;
        for (cycle = 0; cycle < reset_cycles + test_cycles; cycle++) begin
            @(posedge clk);
            #1;
            if (cycle == reset_cycles - 1)
                rst = 1'b0;
            drive_inputs(cycle >= reset_cycles + stall_start);
            // the testbench acts as the ALU for the item in execute
            alu_out_i = m_exe.rs1 + m_exe.rs2;
            br_en_i   = (m_exe.rs1 == m_exe.rs2);
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // margin of 50 cycles over reset plus the test loop
    initial begin
        #((reset_cycles + test_cycles + 50) * clk_period);
        $display("watchdog expired before the test loop finished");
        $display("Some tests failed");
        $finish;
    end

endmodule : tb_stage_regs
